// File: pcUnit.f
cpuPkg.sv
branchDecode.sv
condEval.sv
pcControl.sv
pcUnit.sv
tb_pcUnit.sv

// File: Makefile
TOOL     := verilator
TOP      := tb_pcUnit
FILELIST := pcUnit.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log
PASS     := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS)$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb_pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pcUnit;

  import cpuPkg::*;

  localparam int ClkPeriod   = 8;      // ns
  localparam int ResetCycles = 16;
  localparam int Seed        = 19460;

  // Cycle budget of each test, used by the watchdog
  localparam int SeqCycles    = 11;
  localparam int CondCycles   = 72;    // 8 flag loads times (1 + 8 codes)
  localparam int OffsetCycles = 25;
  localparam int RegCycles    = 40;
  localparam int StallCycles  = 8;
  localparam int MixCycles    = 500;
  localparam int TailCycles   = 3;     // Drain the last compares
  localparam int TotalCycles  = ResetCycles + SeqCycles + CondCycles + OffsetCycles
                              + RegCycles + StallCycles + MixCycles + TailCycles;

  logic                 clk;
  logic                 rst;
  instr_u               instr;
  logic                 stall;
  logic [AddrWidth-1:0] rsData;
  logic [FlagWidth-1:0] flagsIn;
  logic                 flagWrite;
  logic [AddrWidth-1:0] pc;
  logic [3:0]           rsAddr;
  logic                 taken;

  logic [AddrWidth-1:0] expPc;       // Model PC
  logic [FlagWidth-1:0] modelFlags;  // Model Z V N register
  int                   checkCount = 0;
  int                   errorCount = 0;

  pcUnit u_dut (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .stall     (stall),
    .rsData    (rsData),
    .flagsIn   (flagsIn),
    .flagWrite (flagWrite),
    .pc        (pc),
    .rsAddr    (rsAddr),
    .taken     (taken)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Branch decision straight from the condition table
  function automatic logic refTaken(input instr_u ins, input logic [FlagWidth-1:0] fl);
    logic z;
    logic v;
    logic n;
    logic holds;
    logic branch;
    z      = fl[FlagZ];
    v      = fl[FlagV];
    n      = fl[FlagN];
    branch = (ins.bFmt.opcode == OpB) || (ins.bFmt.opcode == OpBr);
    case (ins.bFmt.cond)
      CondNe:  holds = !z;
      CondEq:  holds = z;
      CondGt:  holds = !z && !n;
      CondLt:  holds = n;
      CondGe:  holds = z || (!z && !n);
      CondLe:  holds = z || n;
      CondOv:  holds = v;
      default: holds = 1'b1;          // Al
    endcase
    return branch && holds;
  endfunction

  function automatic logic [AddrWidth-1:0] nextPc(
    input logic [AddrWidth-1:0] cur,
    input instr_u               ins,
    input logic [FlagWidth-1:0] fl,
    input logic [AddrWidth-1:0] rd,
    input logic                 st
  );
    logic [AddrWidth-1:0] seq;
    logic [AddrWidth-1:0] ext;
    logic [AddrWidth-1:0] result;
    seq = cur + 16'd2;                                    // Wraps modulo 2^16
    ext = {{7{ins.bFmt.offset[8]}}, ins.bFmt.offset};     // Word offset, signed
    if (st) begin
      result = cur;                                       // Stall holds
    end else if (!refTaken(ins, fl)) begin
      result = seq;
    end else if (ins.bFmt.opcode == OpBr) begin
      result = rd;
    end else begin
      result = seq + (ext << 1);                          // Byte target
    end
    return result;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks and compare process
  //////////////////////////////////////////////////

  task automatic checkPc(input logic [AddrWidth-1:0] actual, input logic [AddrWidth-1:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail time=%0t signal=pc expected=%h actual=%h", $time, expected, actual);
    end
  endtask

  task automatic checkTaken(input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail time=%0t signal=taken expected=%b actual=%b", $time, expected, actual);
    end
  endtask

  task automatic checkRsAddr(input logic [3:0] actual, input logic [3:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail time=%0t signal=rsAddr expected=%h actual=%h", $time, expected, actual);
    end
  endtask

  // Falling edge, inputs and outputs settled
  always @(negedge clk) begin
    if (rst) begin
      expPc      = '0;
      modelFlags = '0;
    end else begin
      checkPc(pc, expPc);
      checkTaken(taken, refTaken(instr, modelFlags));
      checkRsAddr(rsAddr, instr.raw[7:4]);                // BR source field
      expPc = nextPc(expPc, instr, modelFlags, rsData, stall);
      if (flagWrite) begin
        modelFlags = flagsIn;                             // Seen from next cycle on
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $urandom;
    return r[15:0];
  endfunction

  function automatic logic [15:0] makeB(input logic [2:0] cond, input logic [8:0] offset);
    return {OpB, cond, offset};
  endfunction

  function automatic logic [15:0] makeBr(input logic [2:0] cond, input logic [3:0] rs);
    return {OpBr, cond, 1'b0, rs, 4'b0000};
  endfunction

  // Random word with any opcode except the two branches
  function automatic logic [15:0] nonBranch();
    logic [15:0] w;
    w = rand16();
    if (w[15:12] == OpB || w[15:12] == OpBr) begin
      w[15:12] = 4'b0000;
    end
    return w;
  endfunction

  // One cycle of inputs, applied at the rising edge
  task automatic drive(input logic [15:0] word, input logic st, input logic fw,
                       input logic [FlagWidth-1:0] fl, input logic [AddrWidth-1:0] rd);
    @(posedge clk);
    instr.raw <= word;
    stall     <= st;
    flagWrite <= fw;
    flagsIn   <= fl;
    rsData    <= rd;
  endtask

  task automatic reportTest(input int num, input string name, input int errStart);
    $display("Test %0d %s finished with %0d errors", num, name, errorCount - errStart);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic seqFlow();
    int errStart;
    errStart = errorCount;
    repeat (6) drive(nonBranch(), 1'b0, 1'b0, 3'b000, rand16());
    drive(makeBr(CondAl, 4'd3), 1'b0, 1'b0, 3'b000, 16'hFFFC);   // Jump near the top
    repeat (4) drive(nonBranch(), 1'b0, 1'b0, 3'b000, rand16()); // FFFE then 0000
    reportTest(1, "reset and sequential flow", errStart);
  endtask

  task automatic allConds();
    int          errStart;
    logic [15:0] r;
    errStart = errorCount;
    for (int f = 0; f < 8; f++) begin
      drive(nonBranch(), 1'b0, 1'b1, f[2:0], rand16());        // Load flags
      for (int c = 0; c < 8; c++) begin
        r = rand16();
        drive(makeB(c[2:0], r[8:0]), 1'b0, 1'b0, 3'b000, rand16());
      end
    end
    reportTest(2, "all conditions", errStart);
  endtask

  task automatic offsets();
    int          errStart;
    logic [15:0] r;
    errStart = errorCount;
    drive(makeB(CondAl, 9'h0FF), 1'b0, 1'b0, 3'b000, 16'h0000); // +255
    drive(makeB(CondAl, 9'h100), 1'b0, 1'b0, 3'b000, 16'h0000); // -256
    drive(makeB(CondAl, 9'h000), 1'b0, 1'b0, 3'b000, 16'h0000);
    drive(makeB(CondAl, 9'h001), 1'b0, 1'b0, 3'b000, 16'h0000);
    drive(makeB(CondAl, 9'h1FF), 1'b0, 1'b0, 3'b000, 16'h0000); // -1
    repeat (OffsetCycles - 5) begin
      r = rand16();
      drive(makeB(CondAl, r[8:0]), 1'b0, 1'b0, 3'b000, rand16());
    end
    reportTest(3, "offsets", errStart);
  endtask

  task automatic regBranch();
    int          errStart;
    logic [15:0] r;
    logic [15:0] d;
    errStart = errorCount;
    repeat (RegCycles) begin
      r    = rand16();
      d    = rand16();
      d[0] = 1'b0;                                              // Even target
      drive(makeBr(r[2:0], r[7:4]), 1'b0, r[8], r[11:9], d);
    end
    reportTest(4, "register branch", errStart);
  endtask

  task automatic stallFlags();
    int errStart;
    errStart = errorCount;
    drive(nonBranch(), 1'b0, 1'b1, 3'b000, 16'h0000);           // Clear flags
    drive(makeB(CondEq, 9'h004), 1'b1, 1'b1, 3'b100, 16'h0000); // Z loaded in stall
    drive(makeB(CondEq, 9'h004), 1'b1, 1'b0, 3'b000, 16'h0000); // Taken but held
    drive(makeB(CondEq, 9'h004), 1'b1, 1'b0, 3'b000, 16'h0000);
    drive(makeB(CondEq, 9'h004), 1'b0, 1'b0, 3'b000, 16'h0000); // Released
    drive(makeB(CondEq, 9'h1FE), 1'b0, 1'b1, 3'b000, 16'h0000); // Old Z still used
    drive(makeB(CondEq, 9'h004), 1'b0, 1'b0, 3'b000, 16'h0000); // Z now clear
    drive(makeB(CondNe, 9'h004), 1'b0, 1'b0, 3'b000, 16'h0000);
    reportTest(5, "stall and flag timing", errStart);
  endtask

  task automatic randomMix();
    int          errStart;
    logic [15:0] r;
    logic [15:0] d;
    logic [15:0] w;
    errStart = errorCount;
    repeat (MixCycles) begin
      r = rand16();
      d = rand16();
      case (r[1:0])
        2'd0:    w = nonBranch();
        2'd1:    w = makeB(r[4:2], d[8:0]);
        2'd2:    w = makeBr(r[4:2], d[15:12]);
        default: w = rand16();                                  // Any word
      endcase
      drive(w, r[6:5] == 2'b00, r[8:7] == 2'b00, r[11:9], d);   // Stall and write 1 in 4
    end
    reportTest(6, "random mix", errStart);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    $timeformat(-9, 1, " ns", 10);
    void'($urandom(Seed));
    rst       <= 1'b1;
    instr.raw <= 16'h0000;
    stall     <= 1'b0;
    rsData    <= '0;
    flagsIn   <= '0;
    flagWrite <= 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    seqFlow();
    allConds();
    offsets();
    regBranch();
    stallFlags();
    randomMix();
    repeat (TailCycles) @(negedge clk);
    $display("Summary %0d checks %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(2 * TotalCycles * ClkPeriod);
    $display("Timeout after %0d cycles without reaching the end of the tests", 2 * TotalCycles);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module pcUnit (
  input  logic                         clk,
  input  logic                         rst,        // Sync, active high
  input  cpuPkg::instr_u               instr,      // Instruction at pc
  input  logic                         stall,      // Hold pc
  input  logic [cpuPkg::AddrWidth-1:0] rsData,     // Register file read data
  input  logic [cpuPkg::FlagWidth-1:0] flagsIn,    // ALU flags
  input  logic                         flagWrite,  // Flag load strobe
  output logic [cpuPkg::AddrWidth-1:0] pc,
  output logic [3:0]                   rsAddr,     // Register file read address
  output logic                         taken       // Current branch goes
);

  import cpuPkg::*;

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  logic       isBranch;  // Decode to condEval
  logic       isBr;      // Decode to pcControl
  logic [2:0] cond;      // Decode to condEval
  logic [8:0] offset;    // Decode to pcControl

  // Decode stage
  branchDecode uDecode (
    .clk      (clk),
    .instr    (instr),
    .isBranch (isBranch),
    .isBr     (isBr),
    .cond     (cond),
    .offset   (offset),
    .rsAddr   (rsAddr)
  );

  // Execute stage, flags and condition test
  condEval uCond (
    .clk       (clk),
    .rst       (rst),
    .flagsIn   (flagsIn),
    .flagWrite (flagWrite),
    .isBranch  (isBranch),
    .cond      (cond),
    .taken     (taken)
  );

  // Result stage, PC register and target select
  pcControl uPc (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .taken  (taken),
    .isBr   (isBr),
    .offset (offset),
    .rsData (rsData),
    .pc     (pc)
  );

endmodule

`default_nettype wire

// File: pcControl.sv
`timescale 1ns/100ps
`default_nettype none

module pcControl (
  input  logic                         clk,
  input  logic                         rst,     // Sync, active high
  input  logic                         stall,   // Hold pc while high
  input  logic                         taken,   // From condEval
  input  logic                         isBr,    // Register target
  input  logic [8:0]                   offset,  // Signed word offset
  input  logic [cpuPkg::AddrWidth-1:0] rsData,  // Register target value
  output logic [cpuPkg::AddrWidth-1:0] pc
);

  import cpuPkg::*;

  logic [AddrWidth-1:0] pcPlus2;    // Sequential address
  logic [AddrWidth-1:0] offsetExt;  // Sign-extended byte offset
  logic [AddrWidth-1:0] target;     // B destination
  logic [AddrWidth-1:0] pcNext;     // Selected next address

  //////////////////////////////////////////////////
  // Address adders
  //////////////////////////////////////////////////

  // Fall-through address, wraps FFFE to 0000
  assign pcPlus2 = pc + AddrWidth'(2);

  // Word offset to byte offset
  // Sign bit 8 replicated into the top six bits, then shift by one
  assign offsetExt = {{(AddrWidth - 10){offset[8]}}, offset, 1'b0};

  // Relative to the following instruction, modulo 2^16
  assign target = pcPlus2 + offsetExt;

  //////////////////////////////////////////////////
  // Next-PC select
  //////////////////////////////////////////////////

  // Taken decision already includes the condition test
  always_comb begin
    if (taken && isBr) begin
      pcNext = rsData;      // BR to register value
    end else if (taken) begin
      pcNext = target;      // B relative
    end else begin
      pcNext = pcPlus2;     // Not a branch or not taken
    end
  end

  //////////////////////////////////////////////////
  // PC register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;             // Start of program
    end else if (!stall) begin
      pc <= pcNext;
    end
  end

  // Reset vector
  aPcReset : assert property (
    @(posedge clk) rst |=> (pc == '0)
  ) else $error("pc not zero after reset");

  // Stall freezes the fetch address across the edge
  aPcStall : assert property (
    @(posedge clk) disable iff (rst) stall |=> $stable(pc)
  ) else $error("pc moved during stall");

endmodule

`default_nettype wire

// File: condEval.sv
`timescale 1ns/100ps
`default_nettype none

module condEval (
  input  logic                         clk,
  input  logic                         rst,        // Sync, active high
  input  logic [cpuPkg::FlagWidth-1:0] flagsIn,    // From the ALU
  input  logic                         flagWrite,  // One-cycle load strobe
  input  logic                         isBranch,   // From branchDecode
  input  logic [2:0]                   cond,       // From branchDecode
  output logic                         taken       // Branch goes this cycle
);

  import cpuPkg::*;

  logic [FlagWidth-1:0] flags;    // Z V N register
  logic                 condMet;  // Condition true against current flags
  logic                 flagZ;
  logic                 flagV;
  logic                 flagN;

  //////////////////////////////////////////////////
  // Flag register
  //////////////////////////////////////////////////

  // Loads at the edge, so a branch in the write cycle sees old flags
  // No stall input here, flag writes go through during a stall
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flagWrite) begin
      flags <= flagsIn;
    end
  end

  assign flagZ = flags[FlagZ];
  assign flagV = flags[FlagV];
  assign flagN = flags[FlagN];

  //////////////////////////////////////////////////
  // Condition test
  //////////////////////////////////////////////////

  always_comb begin
    condMet = 1'b0;  // All eight codes covered below
    case (cond)
      CondNe: condMet = ~flagZ;                      // Z = 0
      CondEq: condMet = flagZ;                       // Z = 1
      CondGt: condMet = ~flagZ & ~flagN;             // Z = N = 0
      CondLt: condMet = flagN;                       // N = 1
      CondGe: condMet = flagZ | (~flagZ & ~flagN);   // Eq or Gt
      CondLe: condMet = flagZ | flagN;               // Eq or Lt
      CondOv: condMet = flagV;                       // V = 1
      CondAl: condMet = 1'b1;                        // Unconditional
      default: condMet = 1'b0;
    endcase
  end

  // Only a decoded branch can be taken
  assign taken = isBranch & condMet;

  // Flags come only from reset or a loaded ALU value
  aFlagsKnown : assert property (
    @(posedge clk) disable iff (rst) !$isunknown(flags)
  ) else $error("Flag register holds unknown bits");

endmodule

`default_nettype wire

// File: branchDecode.sv
`timescale 1ns/100ps
`default_nettype none

module branchDecode (
  input  logic           clk,       // Only used by the assertion
  input  cpuPkg::instr_u instr,     // Word fetched at the current PC
  output logic           isBranch,  // B or BR
  output logic           isBr,      // BR only
  output logic [2:0]     cond,      // Condition code field
  output logic [8:0]     offset,    // B offset field
  output logic [3:0]     rsAddr     // BR source register
);

  import cpuPkg::*;

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  logic [3:0] opcode;   // Top nibble, same in both formats
  logic       opIsB;    // Plain conditional branch
  logic       opIsBr;   // Register branch

  assign opcode = instr.bFmt.opcode;

  // Two compares against the branch opcodes
  assign opIsB  = (opcode == OpB);
  assign opIsBr = (opcode == OpBr);

  // Any branch form
  assign isBranch = opIsB | opIsBr;

  // Register target select for pcControl
  assign isBr = opIsBr;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////

  // Condition lives in [11:9] for both formats
  assign cond = instr.bFmt.cond;

  // Offset is only meaningful for B
  // pcControl does not select the relative target for BR
  assign offset = instr.bFmt.offset;

  // Register address comes from the BR view of the same word
  // Still driven for B so the register file read is harmless
  assign rsAddr = instr.brFmt.rs;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // A register branch is always a branch
  // condEval gates on isBranch and pcControl selects on isBr
  // so a BR without isBranch would never be taken and fall through to PC+2
  aIsBrIsBranch : assert property (
    @(posedge clk) isBr |-> isBranch
  ) else $error("isBr raised without isBranch");

endmodule

`default_nettype wire

// File: cpuPkg.sv
package cpuPkg;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////

  localparam int AddrWidth = 16;  // PC and register read data
  localparam int FlagWidth = 3;   // Z V N flag vector

  // Flag bit positions within the flag vector
  localparam int FlagZ = 2;       // Zero
  localparam int FlagV = 1;       // Overflow
  localparam int FlagN = 0;       // Negative

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  localparam logic [3:0] OpB  = 4'b1100;  // Conditional branch with 9-bit offset
  localparam logic [3:0] OpBr = 4'b1101;  // Conditional branch to register

  //////////////////////////////////////////////////
  // Branch condition codes
  //////////////////////////////////////////////////

  localparam logic [2:0] CondNe = 3'b000;  // Not equal
  localparam logic [2:0] CondEq = 3'b001;  // Equal
  localparam logic [2:0] CondGt = 3'b010;  // Greater than
  localparam logic [2:0] CondLt = 3'b011;  // Less than
  localparam logic [2:0] CondGe = 3'b100;  // Greater or equal
  localparam logic [2:0] CondLe = 3'b101;  // Less or equal
  localparam logic [2:0] CondOv = 3'b110;  // Overflow set
  localparam logic [2:0] CondAl = 3'b111;  // Always

  //////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////

  // Same 16 bits seen as the B format or the BR format
  // Opcode and condition sit in the same place in both
  typedef union packed {
    logic [15:0] raw;            // Whole fetched word

    struct packed {
      logic [3:0] opcode;        // [15:12]
      logic [2:0] cond;          // [11:9]
      logic [8:0] offset;        // [8:0] signed word offset
    } bFmt;

    struct packed {
      logic [3:0] opcode;        // [15:12]
      logic [2:0] cond;          // [11:9]
      logic       spare;         // [8] unused
      logic [3:0] rs;            // [7:4] source register
      logic [3:0] pad;           // [3:0] unused
    } brFmt;
  } instr_u;

  // Target of a taken B is PC+2 plus offset times two
  // Target of a taken BR is the register value itself

endpackage
